/* verilog.f */
rtl/uarch_pkg.sv
rtl/issue_pkg.sv
rtl/inst_decoder.sv
rtl/operand_scoreboard.sv
rtl/issue_stage.sv
rtl/decode_issue.sv
testbench/decode_issue_checker.sv
testbench/decode_issue_tb.sv

/* Makefile */
# Verilator build and run for the decode/issue testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= decode_issue_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^TB PASSED$$"

clean:
	rm -rf $(OBJ_DIR)

/* testbench/decode_issue_tb.sv */
// testbench for the decode/issue stage
// random TinyRV1 program, models the execute pipes and completions

`timescale 1ns/1ps

module decode_issue_tb;

  localparam int NUM_INSTS     = 300;
  localparam int NUM_PIPES     = 3;
  localparam int SEQ_NUM_BITS  = 5;
  localparam int MAX_INFLIGHT  = 8;
  localparam int TIMEOUT_CYCLES = NUM_INSTS * 40;
  localparam logic [31:0] LW_KEY = 32'h5a5a_0f0f;
  localparam uarch_pkg::op_vec SUBSETS [NUM_PIPES] =
    '{uarch_pkg::TINYRV1_ALL, uarch_pkg::OP_ADD_VEC, uarch_pkg::OP_MUL_VEC};

  logic                   clk;
  logic                   rst;
  logic                   f_valid;
  logic                   f_ready;
  issue_pkg::f_d_msg      f_msg;
  logic [NUM_PIPES-1:0]   x_valid;
  logic [NUM_PIPES-1:0]   x_ready;
  issue_pkg::d_x_msg      x_msg [NUM_PIPES];
  logic                   comp_valid;
  issue_pkg::complete_msg comp_msg;

  logic [31:0]            lfsr_state = 32'h9f55_64b3;
  issue_pkg::f_d_msg      prog     [NUM_INSTS];
  issue_pkg::d_x_msg      exp_msg  [NUM_INSTS];
  logic [31:0]            exp_res  [NUM_INSTS];
  logic                   exp_wen  [NUM_INSTS];
  issue_pkg::complete_msg comp_q [$];
  int                     delay_q [$];
  int fetched, issued, mismatches, failures, stall_len;
  logic f_taken;

  decode_issue #(
    .NUM_PIPES    (NUM_PIPES),
    .SEQ_NUM_BITS (SEQ_NUM_BITS),
    .PIPE_SUBSETS (SUBSETS)
  ) u_decode_issue (
    .clk (clk), .rst (rst),
    .f_valid (f_valid), .f_ready (f_ready), .f_msg (f_msg),
    .x_valid (x_valid), .x_ready (x_ready), .x_msg (x_msg),
    .comp_valid (comp_valid), .comp_msg (comp_msg)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ------------------------------
  // random source and program
  // ------------------------------

  // fibonacci LFSR, taps 32 22 2 1
  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = {lfsr_state[30:0],
                    lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
      v = (v << 1) | lfsr_state[0];
    end
    return v;
  endfunction

  task automatic build_program();
    logic [31:0] rf [8];
    logic [31:0] inst, pc, op1, op2, res;
    logic [2:0]  rd, rs1, rs2;
    logic [11:0] imm12;
    uarch_pkg::rv_uop uop;
    logic        w;
    int          kind;
    for (int r = 0; r < 8; r++) rf[r] = '0;
    for (int i = 0; i < NUM_INSTS; i++) begin
      pc    = 32'h1000 + 32'(4 * i);
      kind  = rand_bits(3) % 7;
      rd    = 3'(rand_bits(3));
      rs1   = 3'(rand_bits(3));
      rs2   = 3'(rand_bits(3));
      imm12 = 12'(rand_bits(12));
      op1   = rf[rs1];
      op2   = {{20{imm12[11]}}, imm12};
      w     = 1'b1;
      case (kind)
        0, 2: begin
          inst = {(kind == 2) ? 7'b0000001 : 7'b0, 2'b0, rs2, 2'b0, rs1, 3'b000,
                  2'b0, rd, 7'b0110011};
          op2  = rf[rs2];
          uop  = (kind == 2) ? uarch_pkg::OP_MUL : uarch_pkg::OP_ADD;
          res  = (kind == 2) ? op1 * op2 : op1 + op2;
        end
        1: begin
          inst = {imm12, 2'b0, rs1, 3'b000, 2'b0, rd, 7'b0010011};
          uop  = uarch_pkg::OP_ADD;
          res  = op1 + op2;
        end
        3: begin
          inst = {imm12, 2'b0, rs1, 3'b010, 2'b0, rd, 7'b0000011};
          uop  = uarch_pkg::OP_LW;
          res  = (op1 + op2) ^ LW_KEY;
        end
        4: begin
          inst = {20'(rand_bits(20)), 2'b0, rd, 7'b1101111};
          op1  = pc;
          op2  = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
          uop  = uarch_pkg::OP_JAL;
          res  = pc + 4;
        end
        5: begin
          inst = {imm12, 2'b0, rs1, 3'b000, 2'b0, rd, 7'b1100111};
          uop  = uarch_pkg::OP_JALR;
          res  = pc + 4;
        end
        default: begin
          inst = {7'(rand_bits(7)), 2'b0, rs2, 2'b0, rs1, 3'b001, 5'(rand_bits(5)),
                  7'b1100011};
          op2  = rf[rs2];
          uop  = uarch_pkg::OP_BNE;
          res  = '0;
          w    = 1'b0;
          rd   = '0;
        end
      endcase
      prog[i] = '{pc: pc, inst: inst};
      exp_msg[i] = '{pc: pc, op1: op1, op2: op2, waddr: 5'(rd), uop: uop,
                     seq_num: 8'(i % (1 << SEQ_NUM_BITS))};
      exp_res[i] = res;
      exp_wen[i] = w;
      if (w && rd != 0) rf[rd] = res;
    end
  endtask

  // ------------------------------
  // compare tasks
  // ------------------------------

  task automatic check_issue(input issue_pkg::d_x_msg got, input issue_pkg::d_x_msg exp);
    if (got !== exp) begin
      mismatches++;
      $display("mismatch at %0t: inst %0d got pc=%h uop=%s waddr=%0d op1=%h op2=%h seq=%0d",
               $time, issued, got.pc, got.uop.name(), got.waddr, got.op1, got.op2,
               got.seq_num);
      $display("mismatch at %0t: inst %0d exp pc=%h uop=%s waddr=%0d op1=%h op2=%h seq=%0d",
               $time, issued, exp.pc, exp.uop.name(), exp.waddr, exp.op1, exp.op2,
               exp.seq_num);
    end
  endtask

  task automatic check_pipe(input int pipe, input uarch_pkg::rv_uop uop);
    uarch_pkg::op_vec need;
    case (uop)
      uarch_pkg::OP_ADD:  need = uarch_pkg::OP_ADD_VEC;
      uarch_pkg::OP_MUL:  need = uarch_pkg::OP_MUL_VEC;
      uarch_pkg::OP_LW:   need = uarch_pkg::OP_LW_VEC;
      uarch_pkg::OP_JAL:  need = uarch_pkg::OP_JAL_VEC;
      uarch_pkg::OP_JALR: need = uarch_pkg::OP_JALR_VEC;
      default:            need = uarch_pkg::OP_BNE_VEC;
    endcase
    if ((SUBSETS[pipe] & need) == '0) begin
      mismatches++;
      $display("mismatch at %0t: %s issued on pipe %0d outside its subset",
               $time, uop.name(), pipe);
    end
  endtask

  // ------------------------------
  // per-cycle driver and monitor
  // ------------------------------

  task automatic run_cycle();
    int                     hits;
    issue_pkg::complete_msg done;
    @(negedge clk);
    if (!f_valid || f_taken) begin
      f_valid = 1'b0;
      if (fetched < NUM_INSTS && rand_bits(2) != 0) begin
        f_valid = 1'b1;
        f_msg   = prog[fetched];
      end
    end
    f_taken = 1'b0;
    if (stall_len > 0) begin
      x_ready   = '0;
      stall_len--;
    end else if (rand_bits(4) == 0) begin
      x_ready   = '0;
      stall_len = rand_bits(4);
    end else begin
      x_ready = NUM_PIPES'(rand_bits(NUM_PIPES));
    end
    // limit in-flight work so tags never alias
    if (comp_q.size() >= MAX_INFLIGHT) x_ready = '0;
    comp_valid = 1'b0;
    if (comp_q.size() > 0) begin
      if (delay_q[0] > 0) begin
        delay_q[0]--;
      end else begin
        comp_valid = 1'b1;
        comp_msg   = comp_q.pop_front();
        void'(delay_q.pop_front());
      end
    end
    #1;
    if (f_valid && f_ready) begin
      f_taken = 1'b1;
      fetched++;
    end
    hits = 0;
    for (int p = 0; p < NUM_PIPES; p++) begin
      if (x_valid[p] && x_ready[p]) begin
        hits++;
        if (issued >= fetched) begin
          failures++;
          $display("pipe %0d accepted an instruction that was never fetched", p);
        end else begin
          check_pipe(p, exp_msg[issued].uop);
          check_issue(x_msg[p], exp_msg[issued]);
          done = '{seq_num: x_msg[p].seq_num, waddr: exp_msg[issued].waddr,
                   wdata: exp_res[issued], wen: exp_wen[issued]};
          comp_q.push_back(done);
          delay_q.push_back(rand_bits(2));
        end
        issued++;
      end
    end
    if (hits > 1) begin
      failures++;
      $display("more than one pipe accepted an instruction in one cycle");
    end
  endtask

  initial begin
    rst        = 1'b1;
    f_valid    = 1'b0;
    f_msg      = '0;
    x_ready    = '0;
    comp_valid = 1'b0;
    comp_msg   = '0;
    fetched    = 0;
    issued     = 0;
    mismatches = 0;
    failures   = 0;
    stall_len  = 0;
    f_taken    = 1'b0;
    build_program();
    repeat (16) @(negedge clk);
    rst = 1'b0;
    while (!(issued >= NUM_INSTS && comp_q.size() == 0)) run_cycle();
    // idle tail to catch duplicate issues
    repeat (20) run_cycle();
    if (fetched != NUM_INSTS || issued != fetched) begin
      failures++;
      $display("fetch and issue counts differ, fetched %0d issued %0d", fetched, issued);
    end
    $display("errors: %0d mismatches, %0d other failures, %0d fetched, %0d issued",
             mismatches, failures, fetched, issued);
    if (mismatches == 0 && failures == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("timeout after %0d cycles with %0d of %0d instructions issued",
             TIMEOUT_CYCLES, issued, NUM_INSTS);
    $display("TB FAILED");
    $finish;
  end

endmodule

/* testbench/decode_issue_checker.sv */
// handshake assertions for the decode/issue top level
// one-hot issue, stable offers and quiet outputs in reset

`timescale 1ns/1ps

module decode_issue_checker #(
  parameter int NUM_PIPES = 3
) (
  input logic                   clk,
  input logic                   rst,
  input logic                   f_ready,
  input logic [NUM_PIPES-1:0]   x_valid,
  input logic [NUM_PIPES-1:0]   x_ready,
  input issue_pkg::d_x_msg      x_msg [NUM_PIPES]
);

  // never more than one pipe offered
  assert property (@(posedge clk) disable iff (rst) $onehot0(x_valid))
    else $error("more than one x_valid high");

  // outputs quiet while reset is held
  assert property (@(posedge clk) (rst && $past(rst)) |-> (!f_ready && (x_valid == '0)))
    else $error("f_ready or x_valid high during reset");

  for (genvar p = 0; p < NUM_PIPES; p++) begin : g_pipe
    assert property (@(posedge clk) disable iff (rst)
      (x_valid[p] && !x_ready[p]) |=> (x_valid[p] && $stable(x_msg[p])))
      else $error("pipe %0d offer dropped or changed before accept", p);
  end

endmodule

bind decode_issue decode_issue_checker #(
  .NUM_PIPES (NUM_PIPES)
) u_decode_issue_checker (
  .clk     (clk),
  .rst     (rst),
  .f_ready (f_ready),
  .x_valid (x_valid),
  .x_ready (x_ready),
  .x_msg   (x_msg)
);

/* rtl/decode_issue.sv */
// decode and issue stage top level
// decoder, operand scoreboard and issue stage for the TinyRV1 subset

`timescale 1ns/1ps

module decode_issue #(
  parameter int               NUM_PIPES    = 3,
  parameter int               SEQ_NUM_BITS = 5,
  parameter uarch_pkg::op_vec PIPE_SUBSETS [NUM_PIPES] = '{default: uarch_pkg::TINYRV1_ALL}
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   f_valid,
  output logic                   f_ready,
  input  issue_pkg::f_d_msg      f_msg,
  output logic [NUM_PIPES-1:0]   x_valid,
  input  logic [NUM_PIPES-1:0]   x_ready,
  output issue_pkg::d_x_msg      x_msg [NUM_PIPES],
  input  logic                   comp_valid,
  input  issue_pkg::complete_msg comp_msg
);

  issue_pkg::f_d_msg                   dec_msg;
  uarch_pkg::rv_uop                    uop;
  logic [uarch_pkg::REG_ADDR_BITS-1:0] rs1;
  logic [uarch_pkg::REG_ADDR_BITS-1:0] rs2;
  logic [uarch_pkg::REG_ADDR_BITS-1:0] rd;
  logic [uarch_pkg::XLEN-1:0]          imm;
  logic                                rs1_used;
  logic                                rs2_used;
  logic                                wen;

  logic [uarch_pkg::REG_ADDR_BITS-1:0] sb_rs1;
  logic [uarch_pkg::REG_ADDR_BITS-1:0] sb_rs2;
  logic [uarch_pkg::XLEN-1:0]          rs1_data;
  logic [uarch_pkg::XLEN-1:0]          rs2_data;
  logic                                rs1_pending;
  logic                                rs2_pending;
  logic                                claim_valid;
  logic [uarch_pkg::REG_ADDR_BITS-1:0] claim_addr;
  logic [SEQ_NUM_BITS-1:0]             claim_seq;

  inst_decoder u_inst_decoder (
    .fetch    (dec_msg),
    .uop      (uop),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (rd),
    .imm      (imm),
    .rs1_used (rs1_used),
    .rs2_used (rs2_used),
    .wen      (wen)
  );

  operand_scoreboard #(
    .SEQ_NUM_BITS (SEQ_NUM_BITS)
  ) u_operand_scoreboard (
    .clk         (clk),
    .rst         (rst),
    .rs1         (sb_rs1),
    .rs2         (sb_rs2),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .rs1_pending (rs1_pending),
    .rs2_pending (rs2_pending),
    .claim_valid (claim_valid),
    .claim_addr  (claim_addr),
    .claim_seq   (claim_seq),
    .comp_valid  (comp_valid),
    .comp_msg    (comp_msg)
  );

  issue_stage #(
    .NUM_PIPES    (NUM_PIPES),
    .SEQ_NUM_BITS (SEQ_NUM_BITS),
    .PIPE_SUBSETS (PIPE_SUBSETS)
  ) u_issue_stage (
    .clk         (clk),
    .rst         (rst),
    .f_valid     (f_valid),
    .f_ready     (f_ready),
    .f_msg       (f_msg),
    .dec_msg     (dec_msg),
    .uop         (uop),
    .rs1         (rs1),
    .rs2         (rs2),
    .rd          (rd),
    .imm         (imm),
    .rs1_used    (rs1_used),
    .rs2_used    (rs2_used),
    .wen         (wen),
    .sb_rs1      (sb_rs1),
    .sb_rs2      (sb_rs2),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .rs1_pending (rs1_pending),
    .rs2_pending (rs2_pending),
    .claim_valid (claim_valid),
    .claim_addr  (claim_addr),
    .claim_seq   (claim_seq),
    .x_valid     (x_valid),
    .x_ready     (x_ready),
    .x_msg       (x_msg)
  );

endmodule

/* rtl/issue_stage.sv */
// issue stage holding one fetched instruction
// waits for operands, tags writers with a sequence number, routes to a pipe

`timescale 1ns/1ps

module issue_stage #(
  parameter int               NUM_PIPES    = 3,
  parameter int               SEQ_NUM_BITS = 5,
  parameter uarch_pkg::op_vec PIPE_SUBSETS [NUM_PIPES] = '{default: uarch_pkg::TINYRV1_ALL}
) (
  input  logic                                clk,
  input  logic                                rst,
  // fetch
  input  logic                                f_valid,
  output logic                                f_ready,
  input  issue_pkg::f_d_msg                   f_msg,
  // decoder
  output issue_pkg::f_d_msg                   dec_msg,
  input  uarch_pkg::rv_uop                    uop,
  input  logic [uarch_pkg::REG_ADDR_BITS-1:0] rs1,
  input  logic [uarch_pkg::REG_ADDR_BITS-1:0] rs2,
  input  logic [uarch_pkg::REG_ADDR_BITS-1:0] rd,
  input  logic [uarch_pkg::XLEN-1:0]          imm,
  input  logic                                rs1_used,
  input  logic                                rs2_used,
  input  logic                                wen,
  // scoreboard
  output logic [uarch_pkg::REG_ADDR_BITS-1:0] sb_rs1,
  output logic [uarch_pkg::REG_ADDR_BITS-1:0] sb_rs2,
  input  logic [uarch_pkg::XLEN-1:0]          rs1_data,
  input  logic [uarch_pkg::XLEN-1:0]          rs2_data,
  input  logic                                rs1_pending,
  input  logic                                rs2_pending,
  output logic                                claim_valid,
  output logic [uarch_pkg::REG_ADDR_BITS-1:0] claim_addr,
  output logic [SEQ_NUM_BITS-1:0]             claim_seq,
  // execute pipes
  output logic [NUM_PIPES-1:0]                x_valid,
  input  logic [NUM_PIPES-1:0]                x_ready,
  output issue_pkg::d_x_msg                   x_msg [NUM_PIPES]
);

  localparam int PIPE_BITS = (NUM_PIPES > 1) ? $clog2(NUM_PIPES) : 1;

  issue_pkg::f_d_msg       held;
  logic                    full;
  logic                    started;
  logic [SEQ_NUM_BITS-1:0] seq;
  logic                    locked;
  logic [PIPE_BITS-1:0]    lock_pipe;

  logic [NUM_PIPES-1:0]    capable;
  logic                    found_ready;
  logic                    found_cap;
  logic [PIPE_BITS-1:0]    ready_pick;
  logic [PIPE_BITS-1:0]    cap_pick;
  logic [PIPE_BITS-1:0]    sel;
  logic                    issue_ok;
  logic                    fire;
  issue_pkg::d_x_msg       msg;

  assign dec_msg = held;

  // unused sources read x0, which is never pending
  assign sb_rs1 = rs1_used ? rs1 : '0;
  assign sb_rs2 = rs2_used ? rs2 : '0;

  // ------------------------------
  // pipe selection
  // ------------------------------

  always_comb begin
    found_ready = 1'b0;
    found_cap   = 1'b0;
    ready_pick  = '0;
    cap_pick    = '0;
    for (int p = 0; p < NUM_PIPES; p++) begin
      capable[p] = |(PIPE_SUBSETS[p] & uarch_pkg::uop_mask(uop));
      if (capable[p] && x_ready[p] && !found_ready) begin
        found_ready = 1'b1;
        ready_pick  = PIPE_BITS'(p);
      end
      if (capable[p] && !found_cap) begin
        found_cap = 1'b1;
        cap_pick  = PIPE_BITS'(p);
      end
    end
    // once offered, stay on that pipe until it accepts
    if (locked) begin
      sel = lock_pipe;
    end else begin
      sel = found_ready ? ready_pick : cap_pick;
    end
  end

  assign issue_ok = full && !rs1_pending && !rs2_pending && found_cap;
  assign fire     = issue_ok && x_ready[sel];

  always_comb begin
    for (int p = 0; p < NUM_PIPES; p++) begin
      x_valid[p] = issue_ok && (sel == PIPE_BITS'(p));
    end
  end

  // ------------------------------
  // execute message
  // ------------------------------

  always_comb begin
    msg.pc      = held.pc;
    // jal adds to pc, every other op starts from rs1
    msg.op1     = (uop == uarch_pkg::OP_JAL) ? held.pc : rs1_data;
    msg.op2     = rs2_used ? rs2_data : imm;
    msg.waddr   = rd;
    msg.uop     = uop;
    msg.seq_num = issue_pkg::SEQ_BITS'(seq);
  end

  always_comb begin
    for (int p = 0; p < NUM_PIPES; p++) begin
      x_msg[p] = msg;
    end
  end

  assign claim_valid = fire && wen && (rd != '0);
  assign claim_addr  = rd;
  assign claim_seq   = seq;

  assign f_ready = started && (!full || fire);

  // ------------------------------
  // state
  // ------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      full    <= 1'b0;
      started <= 1'b0;
      locked  <= 1'b0;
      seq     <= '0;
    end else begin
      started <= 1'b1;
      if (f_valid && f_ready) begin
        full <= 1'b1;
      end else if (fire) begin
        full <= 1'b0;
      end
      if (fire) begin
        locked <= 1'b0;
        seq    <= seq + 1'b1;
      end else if (issue_ok) begin
        locked <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (f_valid && f_ready) begin
      held <= f_msg;
    end
    if (issue_ok && !fire) begin
      lock_pipe <= sel;
    end
  end

endmodule

/* rtl/operand_scoreboard.sv */
// register file with a pending bit and owner tag per register
// completions write back and bypass onto the two read ports

`timescale 1ns/1ps

module operand_scoreboard #(
  parameter int SEQ_NUM_BITS = 5
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [uarch_pkg::REG_ADDR_BITS-1:0] rs1,
  input  logic [uarch_pkg::REG_ADDR_BITS-1:0] rs2,
  output logic [uarch_pkg::XLEN-1:0]          rs1_data,
  output logic [uarch_pkg::XLEN-1:0]          rs2_data,
  output logic                                rs1_pending,
  output logic                                rs2_pending,
  input  logic                                claim_valid,
  input  logic [uarch_pkg::REG_ADDR_BITS-1:0] claim_addr,
  input  logic [SEQ_NUM_BITS-1:0]             claim_seq,
  input  logic                                comp_valid,
  input  issue_pkg::complete_msg              comp_msg
);

  typedef struct packed {
    logic                       pending;
    logic [uarch_pkg::XLEN-1:0] data;
  } read_port_t;

  // x0 has no storage
  logic [uarch_pkg::XLEN-1:0] regs    [1:31];
  logic                       pending [1:31];
  logic [SEQ_NUM_BITS-1:0]    owner   [1:31];

  logic                    comp_hit;
  logic [SEQ_NUM_BITS-1:0] comp_seq;
  read_port_t              port1;
  read_port_t              port2;

  assign comp_hit = comp_valid && comp_msg.wen && (comp_msg.waddr != '0);
  assign comp_seq = comp_msg.seq_num[SEQ_NUM_BITS-1:0];

  // ------------------------------
  // read with completion bypass
  // ------------------------------

  function automatic read_port_t read_reg(input logic [uarch_pkg::REG_ADDR_BITS-1:0] addr);
    read_port_t r;
    logic       bypass;
    r      = '0;
    bypass = comp_hit && (comp_msg.waddr == addr);
    if (addr != '0) begin
      r.data = bypass ? comp_msg.wdata : regs[addr];
      // only the owning writer releases the register
      r.pending = pending[addr] && !(bypass && (owner[addr] == comp_seq));
    end
    return r;
  endfunction

  always_comb begin
    port1 = read_reg(rs1);
    port2 = read_reg(rs2);
  end

  assign rs1_data    = port1.data;
  assign rs1_pending = port1.pending;
  assign rs2_data    = port2.data;
  assign rs2_pending = port2.pending;

  // ------------------------------
  // writeback and claim
  // ------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i]    <= '0;
        pending[i] <= 1'b0;
      end
    end else begin
      if (comp_hit) begin
        regs[comp_msg.waddr] <= comp_msg.wdata;
        if (owner[comp_msg.waddr] == comp_seq) begin
          pending[comp_msg.waddr] <= 1'b0;
        end
      end
      // claim comes last so it wins over a same-cycle completion
      if (claim_valid && (claim_addr != '0)) begin
        pending[claim_addr] <= 1'b1;
        owner[claim_addr]   <= claim_seq;
      end
    end
  end

endmodule

/* rtl/inst_decoder.sv */
// TinyRV1 instruction decoder
// turns a fetch message into micro-op, register indices and immediate

`timescale 1ns/1ps

module inst_decoder (
  input  issue_pkg::f_d_msg                    fetch,
  output uarch_pkg::rv_uop                     uop,
  output logic [uarch_pkg::REG_ADDR_BITS-1:0]  rs1,
  output logic [uarch_pkg::REG_ADDR_BITS-1:0]  rs2,
  output logic [uarch_pkg::REG_ADDR_BITS-1:0]  rd,
  output logic [uarch_pkg::XLEN-1:0]           imm,
  output logic                                 rs1_used,
  output logic                                 rs2_used,
  output logic                                 wen
);

  localparam int XLEN = uarch_pkg::XLEN;

  uarch_pkg::inst_word word;
  logic [31:0]         raw;
  logic [XLEN-1:0]     imm_i;
  logic [XLEN-1:0]     imm_b;
  logic [XLEN-1:0]     imm_j;

  assign word = fetch.inst;
  assign raw  = fetch.inst;

  // ------------------------------
  // immediates
  // ------------------------------

  assign imm_i = {{(XLEN-12){raw[31]}}, word.i_view.imm12};
  assign imm_b = {{(XLEN-12){raw[31]}}, raw[7], raw[30:25], raw[11:8], 1'b0};
  // J format scatters the offset, so it comes from the raw bits
  assign imm_j = {{(XLEN-20){raw[31]}}, raw[19:12], raw[20], raw[30:21], 1'b0};

  // ------------------------------
  // opcode decode
  // ------------------------------

  always_comb begin
    uop      = uarch_pkg::OP_ADD;
    rs1      = '0;
    rs2      = '0;
    rd       = '0;
    imm      = '0;
    rs1_used = 1'b0;
    rs2_used = 1'b0;
    wen      = 1'b0;

    case (word.r_view.opcode)
      uarch_pkg::OPC_OP: begin
        // add and mul share the R view, funct7 tells them apart
        uop      = (word.r_view.funct7 == uarch_pkg::F7_MULDIV) ?
                   uarch_pkg::OP_MUL : uarch_pkg::OP_ADD;
        rs1      = word.r_view.rs1;
        rs2      = word.r_view.rs2;
        rd       = word.r_view.rd;
        rs1_used = 1'b1;
        rs2_used = 1'b1;
        wen      = 1'b1;
      end
      uarch_pkg::OPC_OP_IMM, uarch_pkg::OPC_LOAD, uarch_pkg::OPC_JALR: begin
        case (word.i_view.opcode)
          uarch_pkg::OPC_LOAD: uop = uarch_pkg::OP_LW;
          uarch_pkg::OPC_JALR: uop = uarch_pkg::OP_JALR;
          default:             uop = uarch_pkg::OP_ADD;
        endcase
        rs1      = word.i_view.rs1;
        rd       = word.i_view.rd;
        imm      = imm_i;
        rs1_used = 1'b1;
        wen      = 1'b1;
      end
      uarch_pkg::OPC_JAL: begin
        uop = uarch_pkg::OP_JAL;
        rd  = word.r_view.rd;
        imm = imm_j;
        wen = 1'b1;
      end
      uarch_pkg::OPC_BRANCH: begin
        // register fields sit where the R view has them
        uop      = uarch_pkg::OP_BNE;
        rs1      = word.r_view.rs1;
        rs2      = word.r_view.rs2;
        imm      = imm_b;
        rs1_used = 1'b1;
        rs2_used = 1'b1;
      end
      default: begin
        uop = uarch_pkg::OP_ADD;
      end
    endcase
  end

endmodule

/* rtl/issue_pkg.sv */
// decode/issue pipeline messages
// fetch to decode, decode to execute, and the completion notification

package issue_pkg;

  // widest tag carried on the wire, designs use the low bits
  localparam int SEQ_BITS = 8;

  typedef struct packed {
    logic [uarch_pkg::XLEN-1:0] pc;
    uarch_pkg::inst_word        inst;
  } f_d_msg;

  typedef struct packed {
    logic [uarch_pkg::XLEN-1:0]          pc;
    logic [uarch_pkg::XLEN-1:0]          op1;
    logic [uarch_pkg::XLEN-1:0]          op2;
    logic [uarch_pkg::REG_ADDR_BITS-1:0] waddr;
    uarch_pkg::rv_uop                    uop;
    logic [SEQ_BITS-1:0]                 seq_num;
  } d_x_msg;

  // ------------------------------
  // completion, no back-pressure
  // ------------------------------

  typedef struct packed {
    logic [SEQ_BITS-1:0]                 seq_num;
    logic [uarch_pkg::REG_ADDR_BITS-1:0] waddr;
    logic [uarch_pkg::XLEN-1:0]          wdata;
    logic                                wen;
  } complete_msg;

endpackage

/* rtl/uarch_pkg.sv */
// TinyRV1 ISA definitions
// micro-ops, per-pipe op subset masks and the instruction word views

package uarch_pkg;

  localparam int XLEN          = 32;
  localparam int REG_ADDR_BITS = 5;

  typedef enum logic [2:0] {
    OP_ADD,
    OP_MUL,
    OP_LW,
    OP_JAL,
    OP_JALR,
    OP_BNE
  } rv_uop;

  // one bit per micro-op, bit index is the enum value
  typedef logic [5:0] op_vec;

  localparam op_vec OP_ADD_VEC  = 6'b000001;
  localparam op_vec OP_MUL_VEC  = 6'b000010;
  localparam op_vec OP_LW_VEC   = 6'b000100;
  localparam op_vec OP_JAL_VEC  = 6'b001000;
  localparam op_vec OP_JALR_VEC = 6'b010000;
  localparam op_vec OP_BNE_VEC  = 6'b100000;
  localparam op_vec TINYRV1_ALL = 6'b111111;

  // major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  localparam logic [6:0] F7_MULDIV  = 7'b0000001;

  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r_view;
    struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i_view;
  } inst_word;

  function automatic op_vec uop_mask(input rv_uop uop);
    return op_vec'(1) << uop;
  endfunction

endpackage
